//--- hw/core_settings.svh
// Core widths; CORE_REG_BITS must stay 5 since the instruction word has fixed 5-bit register fields
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data word width
`define CORE_XLEN 32

// Register address width
`define CORE_REG_BITS 5

// Instruction memory is word addressed
`define CORE_PC_BITS 10

// Data memory word address
`define CORE_DADDR_BITS 8

`endif

//--- hw/coreIsa_pkg.sv
// Instruction set encodings; 32-bit words only, opcodes above OP_HALT decode as a NOP
`default_nettype none

`include "core_settings.svh"

package coreIsa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_ADDI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_HALT
	} opcode_e;

	// All-zero word is ADD r0,r0,r0
	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB,
		FN_AND,
		FN_OR,
		FN_XOR,
		FN_SLT
	} funct_e;

	typedef struct packed {
		opcode_e opcode;
		logic [`CORE_REG_BITS-1:0] rd;
		logic [`CORE_REG_BITS-1:0] rs;
		logic [`CORE_REG_BITS-1:0] rt;
		logic [4:0] unused;
		funct_e funct;
	} rFields_t;

	// SW stores rd, BEQ compares rd with rs
	typedef struct packed {
		opcode_e opcode;
		logic [`CORE_REG_BITS-1:0] rd;
		logic [`CORE_REG_BITS-1:0] rs;
		logic [15:0] imm;
	} iFields_t;

	typedef union packed {
		rFields_t rFields;
		iFields_t iFields;
	} instrWord_u;

endpackage

`default_nettype wire

//--- hw/corePipe_pkg.sv
// Pipeline-internal selects; not visible on the core ports
`default_nettype none

package corePipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} aluOp_e;

	// Operand source for the instruction in EX
	typedef enum logic [1:0] {
		FROM_REG = 2'd0,
		FROM_MEM,
		FROM_WB
	} fwdSel_e;

endpackage

`default_nettype wire

//--- hw/pipelineControl.sv
// Hazard and forwarding control; writeEn inputs must already be cleared for r0 destinations
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module pipelineControl (
	input  logic clk,
	input  logic rst,
	input  logic [`CORE_REG_BITS-1:0] idSrcA,
	input  logic [`CORE_REG_BITS-1:0] idSrcB,
	input  logic [`CORE_REG_BITS-1:0] exSrcA,
	input  logic [`CORE_REG_BITS-1:0] exSrcB,
	input  logic [`CORE_REG_BITS-1:0] exDest,
	input  logic [`CORE_REG_BITS-1:0] memDest,
	input  logic [`CORE_REG_BITS-1:0] wbDest,
	input  logic exLoad,
	input  logic exTaken,
	input  logic exHalt,
	input  logic memWriteEn,
	input  logic wbWriteEn,
	output logic stall,
	output logic flush,
	output logic frozen,
	output corePipe_pkg::fwdSel_e fwdA,
	output corePipe_pkg::fwdSel_e fwdB
);

	logic loadUse;
	logic frozenReg;

	// Youngest producer wins
	function automatic corePipe_pkg::fwdSel_e pickSource(
		input logic [`CORE_REG_BITS-1:0] src,
		input logic [`CORE_REG_BITS-1:0] memRd,
		input logic memWe,
		input logic [`CORE_REG_BITS-1:0] wbRd,
		input logic wbWe
	);
		if (memWe && memRd == src) begin
			return corePipe_pkg::FROM_MEM;
		end else if (wbWe && wbRd == src) begin
			return corePipe_pkg::FROM_WB;
		end
		return corePipe_pkg::FROM_REG;
	endfunction

	assign fwdA = pickSource(exSrcA, memDest, memWriteEn, wbDest, wbWriteEn);
	assign fwdB = pickSource(exSrcB, memDest, memWriteEn, wbDest, wbWriteEn);

	// Load result is only ready from MEM/WB
	assign loadUse = exLoad && (exDest == idSrcA || exDest == idSrcB);

	assign flush = exTaken || exHalt;
	assign stall = loadUse && !flush;

	// Fetch stops the cycle HALT reaches EX
	assign frozen = frozenReg || exHalt;

	always_ff @(posedge clk) begin
		if (rst) begin
			frozenReg <= 1'b0;
		end else if (exHalt) begin
			frozenReg <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/fetchUnit.sv
// Fetch stage; instruction memory must answer in the same cycle, no wait states
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module fetchUnit (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic flush,
	input  logic frozen,
	input  logic exTaken,
	input  logic [`CORE_PC_BITS-1:0] branchTarget,
	output logic [`CORE_PC_BITS-1:0] instrAddr,
	input  logic [31:0] instrData,
	output coreIsa_pkg::instrWord_u ifInstr,
	output logic [`CORE_PC_BITS-1:0] ifPc
);

	logic [`CORE_PC_BITS-1:0] pc;

	assign instrAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (exTaken) begin
			pc <= branchTarget;
		end else if (!stall && !frozen) begin
			pc <= pc + 1'b1;
		end
	end

	// Frozen keeps feeding NOPs behind HALT
	always_ff @(posedge clk) begin
		if (rst || flush || frozen) begin
			ifInstr <= '0;
		end else if (!stall) begin
			ifInstr <= instrData;
		end
		if (!stall) begin
			ifPc <= pc;
		end
	end

endmodule

`default_nettype wire

//--- hw/decodeUnit.sv
// Decode stage; r0 reads as zero and never gets written, unknown encodings become bubbles
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module decodeUnit (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic flush,
	input  coreIsa_pkg::instrWord_u ifInstr,
	input  logic [`CORE_PC_BITS-1:0] ifPc,
	input  logic [`CORE_REG_BITS-1:0] wbDest,
	input  logic wbWriteEn,
	input  logic [`CORE_XLEN-1:0] wbData,
	output logic [`CORE_REG_BITS-1:0] idSrcA,
	output logic [`CORE_REG_BITS-1:0] idSrcB,
	output logic [`CORE_REG_BITS-1:0] exSrcA,
	output logic [`CORE_REG_BITS-1:0] exSrcB,
	output logic [`CORE_XLEN-1:0] exOpA,
	output logic [`CORE_XLEN-1:0] exOpB,
	output logic [`CORE_XLEN-1:0] exImm,
	output logic [`CORE_PC_BITS-1:0] exPc,
	output corePipe_pkg::aluOp_e exAluOp,
	output logic exUseImm,
	output logic [`CORE_REG_BITS-1:0] exDest,
	output logic exWriteEn,
	output logic exLoad,
	output logic exStore,
	output logic exBranch,
	output logic exHalt
);

	logic [`CORE_XLEN-1:0] regFile [2**`CORE_REG_BITS];
	logic [`CORE_REG_BITS-1:0] dest;
	logic [`CORE_XLEN-1:0] rdA;
	logic [`CORE_XLEN-1:0] rdB;
	logic [`CORE_XLEN-1:0] immExt;
	corePipe_pkg::aluOp_e aluOp;
	logic writeReq;
	logic writeEn;
	logic useImm;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isHalt;

	always_ff @(posedge clk) begin
		if (wbWriteEn) begin
			regFile[wbDest] <= wbData;
		end
	end

	// Write-through so WB and ID can share a cycle
	assign rdA = (idSrcA == '0) ? '0 :
		(wbWriteEn && wbDest == idSrcA) ? wbData : regFile[idSrcA];
	assign rdB = (idSrcB == '0) ? '0 :
		(wbWriteEn && wbDest == idSrcB) ? wbData : regFile[idSrcB];

	assign immExt = {{(`CORE_XLEN-16){ifInstr.iFields.imm[15]}}, ifInstr.iFields.imm};

	always_comb begin
		idSrcA = '0;
		idSrcB = '0;
		dest = '0;
		aluOp = corePipe_pkg::ALU_ADD;
		writeReq = 1'b0;
		useImm = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isBranch = 1'b0;
		isHalt = 1'b0;
		case (ifInstr.rFields.opcode)
			coreIsa_pkg::OP_RTYPE: begin
				idSrcA = ifInstr.rFields.rs;
				idSrcB = ifInstr.rFields.rt;
				dest = ifInstr.rFields.rd;
				writeReq = 1'b1;
				case (ifInstr.rFields.funct)
					coreIsa_pkg::FN_ADD: aluOp = corePipe_pkg::ALU_ADD;
					coreIsa_pkg::FN_SUB: aluOp = corePipe_pkg::ALU_SUB;
					coreIsa_pkg::FN_AND: aluOp = corePipe_pkg::ALU_AND;
					coreIsa_pkg::FN_OR:  aluOp = corePipe_pkg::ALU_OR;
					coreIsa_pkg::FN_XOR: aluOp = corePipe_pkg::ALU_XOR;
					coreIsa_pkg::FN_SLT: aluOp = corePipe_pkg::ALU_SLT;
					default: writeReq = 1'b0;
				endcase
			end
			coreIsa_pkg::OP_ADDI, coreIsa_pkg::OP_LW: begin
				idSrcA = ifInstr.iFields.rs;
				dest = ifInstr.iFields.rd;
				writeReq = 1'b1;
				useImm = 1'b1;
				isLoad = (ifInstr.iFields.opcode == coreIsa_pkg::OP_LW);
			end
			coreIsa_pkg::OP_SW: begin
				idSrcA = ifInstr.iFields.rs;
				idSrcB = ifInstr.iFields.rd;
				useImm = 1'b1;
				isStore = 1'b1;
			end
			coreIsa_pkg::OP_BEQ: begin
				idSrcA = ifInstr.iFields.rs;
				idSrcB = ifInstr.iFields.rd;
				aluOp = corePipe_pkg::ALU_SUB;
				isBranch = 1'b1;
			end
			coreIsa_pkg::OP_HALT: isHalt = 1'b1;
			default: ;
		endcase
	end

	assign writeEn = writeReq && (dest != '0);

	always_ff @(posedge clk) begin
		if (rst || stall || flush) begin
			exWriteEn <= 1'b0;
			exLoad <= 1'b0;
			exStore <= 1'b0;
			exBranch <= 1'b0;
			exHalt <= 1'b0;
		end else begin
			exWriteEn <= writeEn;
			// A load into r0 is dropped here, so it never stalls
			exLoad <= isLoad && writeEn;
			exStore <= isStore;
			exBranch <= isBranch;
			exHalt <= isHalt;
		end
		exSrcA <= idSrcA;
		exSrcB <= idSrcB;
		exOpA <= rdA;
		exOpB <= rdB;
		exImm <= immExt;
		exPc <= ifPc;
		exAluOp <= aluOp;
		exUseImm <= useImm;
		exDest <= dest;
	end

endmodule

`default_nettype wire

//--- hw/executeUnit.sv
// Execute stage; branches resolve here with not-taken prediction, target is PC+1+imm
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module executeUnit (
	input  logic clk,
	input  logic rst,
	input  corePipe_pkg::fwdSel_e fwdA,
	input  corePipe_pkg::fwdSel_e fwdB,
	input  logic [`CORE_XLEN-1:0] exOpA,
	input  logic [`CORE_XLEN-1:0] exOpB,
	input  logic [`CORE_XLEN-1:0] exImm,
	input  logic [`CORE_PC_BITS-1:0] exPc,
	input  corePipe_pkg::aluOp_e exAluOp,
	input  logic exUseImm,
	input  logic [`CORE_REG_BITS-1:0] exDest,
	input  logic exWriteEn,
	input  logic exLoad,
	input  logic exStore,
	input  logic exBranch,
	input  logic exHalt,
	input  logic [`CORE_XLEN-1:0] wbData,
	output logic exTaken,
	output logic [`CORE_PC_BITS-1:0] branchTarget,
	output logic [`CORE_XLEN-1:0] memResult,
	output logic [`CORE_XLEN-1:0] memStoreData,
	output logic [`CORE_REG_BITS-1:0] memDest,
	output logic memWriteEn,
	output logic memLoad,
	output logic memStore,
	output logic memHalt
);

	logic [`CORE_XLEN-1:0] opA;
	logic [`CORE_XLEN-1:0] opB;
	logic [`CORE_XLEN-1:0] aluB;
	logic [`CORE_XLEN-1:0] aluOut;

	function automatic logic [`CORE_XLEN-1:0] forwardMux(
		input corePipe_pkg::fwdSel_e sel,
		input logic [`CORE_XLEN-1:0] regVal,
		input logic [`CORE_XLEN-1:0] memVal,
		input logic [`CORE_XLEN-1:0] wbVal
	);
		case (sel)
			corePipe_pkg::FROM_MEM: return memVal;
			corePipe_pkg::FROM_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = forwardMux(fwdA, exOpA, memResult, wbData);
	assign opB = forwardMux(fwdB, exOpB, memResult, wbData);
	assign aluB = exUseImm ? exImm : opB;

	always_comb begin
		case (exAluOp)
			corePipe_pkg::ALU_SUB: aluOut = opA - aluB;
			corePipe_pkg::ALU_AND: aluOut = opA & aluB;
			corePipe_pkg::ALU_OR:  aluOut = opA | aluB;
			corePipe_pkg::ALU_XOR: aluOut = opA ^ aluB;
			corePipe_pkg::ALU_SLT: aluOut = {{(`CORE_XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
			default: aluOut = opA + aluB;
		endcase
	end

	// BEQ compares rs with rd
	assign exTaken = exBranch && (opA == opB);
	assign branchTarget = exPc + 1'b1 + exImm[`CORE_PC_BITS-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			memWriteEn <= 1'b0;
			memLoad <= 1'b0;
			memStore <= 1'b0;
			memHalt <= 1'b0;
		end else begin
			memWriteEn <= exWriteEn;
			memLoad <= exLoad;
			memStore <= exStore;
			memHalt <= exHalt;
		end
		memResult <= aluOut;
		memStoreData <= opB;
		memDest <= exDest;
	end

endmodule

`default_nettype wire

//--- hw/memoryAccess.sv
// Memory stage; data memory must return load data combinationally, addresses wrap at CORE_DADDR_BITS
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module memoryAccess (
	input  logic clk,
	input  logic rst,
	input  logic [`CORE_XLEN-1:0] memResult,
	input  logic [`CORE_XLEN-1:0] memStoreData,
	input  logic [`CORE_REG_BITS-1:0] memDest,
	input  logic memWriteEn,
	input  logic memLoad,
	input  logic memStore,
	input  logic memHalt,
	output logic [`CORE_DADDR_BITS-1:0] dataAddr,
	output logic [`CORE_XLEN-1:0] dataWrData,
	output logic dataWe,
	input  logic [`CORE_XLEN-1:0] dataRdData,
	output logic [`CORE_XLEN-1:0] wbData,
	output logic [`CORE_REG_BITS-1:0] wbDest,
	output logic wbWriteEn,
	output logic halt
);

	assign dataAddr = memResult[`CORE_DADDR_BITS-1:0];
	assign dataWrData = memStoreData;
	assign dataWe = memStore;

	always_ff @(posedge clk) begin
		if (rst) begin
			wbWriteEn <= 1'b0;
		end else begin
			wbWriteEn <= memWriteEn;
		end
		wbData <= memLoad ? dataRdData : memResult;
		wbDest <= memDest;
	end

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (rst) begin
			halt <= 1'b0;
		end else if (memHalt) begin
			halt <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/tinyCore.sv
// Five-stage core top; both memories answer in the same cycle and a store is a one-cycle dataWe
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module tinyCore (
	input  logic clk,
	input  logic rst,
	output logic [`CORE_PC_BITS-1:0] instrAddr,
	input  logic [31:0] instrData,
	output logic [`CORE_DADDR_BITS-1:0] dataAddr,
	output logic [`CORE_XLEN-1:0] dataWrData,
	output logic dataWe,
	input  logic [`CORE_XLEN-1:0] dataRdData,
	output logic halt
);

	logic stall;
	logic flush;
	logic frozen;
	corePipe_pkg::fwdSel_e fwdA;
	corePipe_pkg::fwdSel_e fwdB;
	coreIsa_pkg::instrWord_u ifInstr;
	logic [`CORE_PC_BITS-1:0] ifPc;
	logic [`CORE_REG_BITS-1:0] idSrcA;
	logic [`CORE_REG_BITS-1:0] idSrcB;
	logic [`CORE_REG_BITS-1:0] exSrcA;
	logic [`CORE_REG_BITS-1:0] exSrcB;
	logic [`CORE_XLEN-1:0] exOpA;
	logic [`CORE_XLEN-1:0] exOpB;
	logic [`CORE_XLEN-1:0] exImm;
	logic [`CORE_PC_BITS-1:0] exPc;
	corePipe_pkg::aluOp_e exAluOp;
	logic exUseImm;
	logic [`CORE_REG_BITS-1:0] exDest;
	logic exWriteEn;
	logic exLoad;
	logic exStore;
	logic exBranch;
	logic exHalt;
	logic exTaken;
	logic [`CORE_PC_BITS-1:0] branchTarget;
	logic [`CORE_XLEN-1:0] memResult;
	logic [`CORE_XLEN-1:0] memStoreData;
	logic [`CORE_REG_BITS-1:0] memDest;
	logic memWriteEn;
	logic memLoad;
	logic memStore;
	logic memHalt;
	logic [`CORE_XLEN-1:0] wbData;
	logic [`CORE_REG_BITS-1:0] wbDest;
	logic wbWriteEn;

	pipelineControl control (
		.clk(clk),
		.rst(rst),
		.idSrcA(idSrcA),
		.idSrcB(idSrcB),
		.exSrcA(exSrcA),
		.exSrcB(exSrcB),
		.exDest(exDest),
		.memDest(memDest),
		.wbDest(wbDest),
		.exLoad(exLoad),
		.exTaken(exTaken),
		.exHalt(exHalt),
		.memWriteEn(memWriteEn),
		.wbWriteEn(wbWriteEn),
		.stall(stall),
		.flush(flush),
		.frozen(frozen),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

	fetchUnit fetch (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.flush(flush),
		.frozen(frozen),
		.exTaken(exTaken),
		.branchTarget(branchTarget),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.ifInstr(ifInstr),
		.ifPc(ifPc)
	);

	decodeUnit decode (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.flush(flush),
		.ifInstr(ifInstr),
		.ifPc(ifPc),
		.wbDest(wbDest),
		.wbWriteEn(wbWriteEn),
		.wbData(wbData),
		.idSrcA(idSrcA),
		.idSrcB(idSrcB),
		.exSrcA(exSrcA),
		.exSrcB(exSrcB),
		.exOpA(exOpA),
		.exOpB(exOpB),
		.exImm(exImm),
		.exPc(exPc),
		.exAluOp(exAluOp),
		.exUseImm(exUseImm),
		.exDest(exDest),
		.exWriteEn(exWriteEn),
		.exLoad(exLoad),
		.exStore(exStore),
		.exBranch(exBranch),
		.exHalt(exHalt)
	);

	executeUnit execute (
		.clk(clk),
		.rst(rst),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.exOpA(exOpA),
		.exOpB(exOpB),
		.exImm(exImm),
		.exPc(exPc),
		.exAluOp(exAluOp),
		.exUseImm(exUseImm),
		.exDest(exDest),
		.exWriteEn(exWriteEn),
		.exLoad(exLoad),
		.exStore(exStore),
		.exBranch(exBranch),
		.exHalt(exHalt),
		.wbData(wbData),
		.exTaken(exTaken),
		.branchTarget(branchTarget),
		.memResult(memResult),
		.memStoreData(memStoreData),
		.memDest(memDest),
		.memWriteEn(memWriteEn),
		.memLoad(memLoad),
		.memStore(memStore),
		.memHalt(memHalt)
	);

	memoryAccess memory (
		.clk(clk),
		.rst(rst),
		.memResult(memResult),
		.memStoreData(memStoreData),
		.memDest(memDest),
		.memWriteEn(memWriteEn),
		.memLoad(memLoad),
		.memStore(memStore),
		.memHalt(memHalt),
		.dataAddr(dataAddr),
		.dataWrData(dataWrData),
		.dataWe(dataWe),
		.dataRdData(dataRdData),
		.wbData(wbData),
		.wbDest(wbDest),
		.wbWriteEn(wbWriteEn),
		.halt(halt)
	);

endmodule

`default_nettype wire

//--- test/tinyCore_sva.sv
// Output checks bound into tinyCore; they rely on the synchronous active-high reset from the testbench
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module tinyCoreSva (
	input logic clk,
	input logic rst,
	input logic [`CORE_PC_BITS-1:0] instrAddr,
	input logic dataWe,
	input logic halt
);

	// Sticky until the next reset
	haltHolds: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
		else $error("halt fell while reset was low");

	noStoreAfterHalt: assert property (@(posedge clk) disable iff (rst) !(dataWe && halt))
		else $error("dataWe high while halt is high");

	quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> (!dataWe && !halt))
		else $error("dataWe or halt high in the first cycle after reset");

	pcKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(instrAddr))
		else $error("instrAddr holds an unknown value");

endmodule

bind tinyCore tinyCoreSva checks (
	.clk(clk),
	.rst(rst),
	.instrAddr(instrAddr),
	.dataWe(dataWe),
	.halt(halt)
);

`default_nettype wire

//--- test/tinyCoreTb.sv
// Random-program testbench; programs only touch r0-r7, and r1-r7 are set up by the first words
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module tinyCoreTb;

	localparam logic [31:0] Seed = 32'h01e0fe76;
	localparam int Programs = 4;
	localparam int ProgWords = 96;
	localparam int InitRegs = 7;
	localparam int ResetCycles = 5;
	localparam int PostHaltCycles = 4;
	// About three cycles per instruction plus reset and drain
	localparam int CycleLimit = Programs * 400;
	localparam int ImemWords = 2 ** `CORE_PC_BITS;
	localparam int DmemWords = 2 ** `CORE_DADDR_BITS;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [`CORE_PC_BITS-1:0] instrAddr;
	logic [31:0] instrData;
	logic [`CORE_DADDR_BITS-1:0] dataAddr;
	logic [`CORE_XLEN-1:0] dataWrData;
	logic dataWe;
	logic [`CORE_XLEN-1:0] dataRdData;
	logic halt;

	logic [31:0] imem [ImemWords];
	logic [`CORE_XLEN-1:0] dmem [DmemWords];
	logic [`CORE_XLEN-1:0] modelMem [DmemWords];
	logic [`CORE_XLEN-1:0] modelReg [32];
	logic [`CORE_DADDR_BITS-1:0] expAddr [$];
	logic [`CORE_XLEN-1:0] expData [$];
	logic [4:0] recent [3];
	int cycles = 0;

	tinyCore uut (
		.clk(clk),
		.rst(rst),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.dataAddr(dataAddr),
		.dataWrData(dataWrData),
		.dataWe(dataWe),
		.dataRdData(dataRdData),
		.halt(halt)
	);

	// Both memories answer in the same cycle
	assign instrData = imem[instrAddr];
	assign dataRdData = dmem[dataAddr];

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("Timeout: the programs did not finish within %0d cycles", CycleLimit);
			$display("TEST FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "stopping at the first error");
		end
	endtask

	function automatic void noteDest(input logic [4:0] d);
		recent[2] = recent[1];
		recent[1] = recent[0];
		recent[0] = d;
	endfunction

	// Mostly one of the last three destinations
	function automatic logic [4:0] pickSource();
		if ($urandom_range(9) < 6) begin
			return recent[$urandom_range(2)];
		end
		return 5'($urandom_range(7));
	endfunction

	function automatic logic [4:0] pickDest();
		logic [4:0] d;
		d = 5'($urandom_range(7));
		noteDest(d);
		return d;
	endfunction

	task automatic buildProgram();
		coreIsa_pkg::instrWord_u w;
		int kind;
		int maxOff;
		for (int a = 0; a < ImemWords; a++) begin
			imem[a] = '0;
		end
		for (int r = 1; r <= InitRegs; r++) begin
			w = '0;
			w.iFields.opcode = coreIsa_pkg::OP_ADDI;
			w.iFields.rd = 5'(r);
			w.iFields.imm = 16'($urandom());
			imem[r - 1] = w;
		end
		recent[0] = 5'd7;
		recent[1] = 5'd6;
		recent[2] = 5'd5;
		for (int i = InitRegs; i < ProgWords - 1; i++) begin
			w = '0;
			kind = $urandom_range(99);
			if (kind < 35) begin
				w.rFields.opcode = coreIsa_pkg::OP_RTYPE;
				w.rFields.rs = pickSource();
				w.rFields.rt = pickSource();
				w.rFields.funct = coreIsa_pkg::funct_e'($urandom_range(5));
				w.rFields.rd = pickDest();
			end else if (kind < 70) begin
				w.iFields.opcode = (kind < 55) ? coreIsa_pkg::OP_ADDI : coreIsa_pkg::OP_LW;
				w.iFields.rs = pickSource();
				w.iFields.imm = 16'($urandom());
				w.iFields.rd = pickDest();
			end else if (kind < 85) begin
				w.iFields.opcode = coreIsa_pkg::OP_SW;
				w.iFields.rs = pickSource();
				w.iFields.rd = pickSource();
				w.iFields.imm = 16'($urandom());
			end else begin
				w.iFields.opcode = coreIsa_pkg::OP_BEQ;
				w.iFields.rs = pickSource();
				w.iFields.rd = ($urandom_range(9) < 4) ? w.iFields.rs : pickSource();
				// Forward only, never past HALT
				maxOff = (ProgWords - 2 - i < 4) ? ProgWords - 2 - i : 4;
				w.iFields.imm = 16'($urandom_range(maxOff));
			end
			imem[i] = w;
		end
		w = '0;
		w.iFields.opcode = coreIsa_pkg::OP_HALT;
		imem[ProgWords - 1] = w;
	endtask

	task automatic fillDataMemory();
		for (int a = 0; a < DmemWords; a++) begin
			dmem[a] = $urandom();
			modelMem[a] = dmem[a];
		end
	endtask

	function automatic logic [31:0] aluResult(input coreIsa_pkg::funct_e fn,
		input logic [31:0] a, input logic [31:0] b);
		case (fn)
			coreIsa_pkg::FN_SUB: return a - b;
			coreIsa_pkg::FN_AND: return a & b;
			coreIsa_pkg::FN_OR:  return a | b;
			coreIsa_pkg::FN_XOR: return a ^ b;
			coreIsa_pkg::FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return a + b;
		endcase
	endfunction

	function automatic void writeReg(input logic [4:0] rd, input logic [31:0] value);
		if (rd != 5'd0) begin
			modelReg[rd] = value;
		end
	endfunction

	// Architectural run that records every store in program order
	task automatic runModel();
		coreIsa_pkg::instrWord_u w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] sum;
		logic [`CORE_DADDR_BITS-1:0] addr;
		int pc;
		int steps;
		bit done;
		expAddr.delete();
		expData.delete();
		for (int r = 0; r < 32; r++) begin
			modelReg[r] = '0;
		end
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < ProgWords) begin
			w = imem[pc];
			a = modelReg[w.iFields.rs];
			b = modelReg[w.rFields.rt];
			imm = {{16{w.iFields.imm[15]}}, w.iFields.imm};
			sum = a + imm;
			addr = sum[`CORE_DADDR_BITS-1:0];
			pc = pc + 1;
			case (w.rFields.opcode)
				coreIsa_pkg::OP_RTYPE: writeReg(w.rFields.rd, aluResult(w.rFields.funct, a, b));
				coreIsa_pkg::OP_ADDI: writeReg(w.iFields.rd, sum);
				coreIsa_pkg::OP_LW: writeReg(w.iFields.rd, modelMem[addr]);
				coreIsa_pkg::OP_SW: begin
					expAddr.push_back(addr);
					expData.push_back(modelReg[w.iFields.rd]);
					modelMem[addr] = modelReg[w.iFields.rd];
				end
				coreIsa_pkg::OP_BEQ: begin
					if (modelReg[w.iFields.rd] == a) begin
						pc = pc + $signed(imm);
					end
				end
				coreIsa_pkg::OP_HALT: done = 1'b1;
				default: ;
			endcase
			steps++;
		end
	endtask

	task automatic runProgram(input int prog);
		int seen;
		@(negedge clk);
		rst = 1'b1;
		buildProgram();
		fillDataMemory();
		runModel();
		repeat (ResetCycles) begin
			@(negedge clk);
			checkEq(32'(dataWe), 32'd0, "dataWe low during reset");
			checkEq(32'(halt), 32'd0, "halt low during reset");
			checkEq(32'(instrAddr), 32'd0, "instrAddr zero during reset");
		end
		rst = 1'b0;
		seen = 0;
		@(negedge clk);
		checkEq(32'(dataWe), 32'd0, "dataWe low in the first cycle after reset");
		checkEq(32'(halt), 32'd0, "halt low in the first cycle after reset");
		while (!halt) begin
			if (dataWe) begin
				checkEq(32'(seen < expAddr.size()), 32'd1,
					$sformatf("program %0d store beyond the model's last store", prog));
				checkEq(32'(dataAddr), 32'(expAddr[seen]),
					$sformatf("program %0d store %0d address", prog, seen));
				checkEq(dataWrData, expData[seen],
					$sformatf("program %0d store %0d data", prog, seen));
				dmem[dataAddr] = dataWrData;
				seen++;
			end
			@(negedge clk);
		end
		checkEq(32'(seen), 32'(expAddr.size()), $sformatf("program %0d store count", prog));
		checkEq(32'(dataWe), 32'd0, "no store in the cycle halt rises");
		repeat (PostHaltCycles) begin
			@(negedge clk);
			checkEq(32'(halt), 32'd1, "halt stays high");
			checkEq(32'(dataWe), 32'd0, "no store after halt");
		end
	endtask

	initial begin
		void'($urandom(Seed));
		for (int a = 0; a < ImemWords; a++) begin
			imem[a] = '0;
		end
		for (int a = 0; a < DmemWords; a++) begin
			dmem[a] = '0;
		end
		for (int p = 0; p < Programs; p++) begin
			runProgram(p);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- tinyCore.f
+incdir+hw
hw/coreIsa_pkg.sv
hw/corePipe_pkg.sv
hw/pipelineControl.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/executeUnit.sv
hw/memoryAccess.sv
hw/tinyCore.sv
test/tinyCore_sva.sv
test/tinyCoreTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator, then decides pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tinyCoreTb -f tinyCore.f \
	&& ./obj_dir/VtinyCoreTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
